// ==== Bender.yml ====
package:
  name: bno055_driver

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - imu_pkg.sv
      - imu_rx_if.sv
      - imu_ms_timer.sv
      - imu_sequencer.sv
      - imu_burst_capture.sv
      - bno055_driver.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_i2c_model.sv
      - tb_bno055_driver.sv

// ==== all.f ====
+incdir+.
imu_pkg.sv
imu_rx_if.sv
imu_ms_timer.sv
imu_sequencer.sv
imu_burst_capture.sv
bno055_driver.sv
tb_i2c_model.sv
tb_bno055_driver.sv

// ==== bno055_driver.sv ====
// BNO055 host controller top level
// Delay timer, sequencer and burst capture around an external I2C engine

`timescale 1ns/1ps

module bno055_driver #(
	parameter int unsigned CYCLES_PER_MS = 50000,
	parameter int unsigned BOOT_MS       = 650
) (
	input  logic                sys_clk,
	input  logic                rstn,
	output logic                i2c_go,
	output logic                i2c_read,
	output imu_pkg::byte_t      i2c_reg_addr,
	output imu_pkg::byte_t      i2c_wdata,
	output imu_pkg::burst_idx_t i2c_read_count,
	input  logic                i2c_busy,
	input  imu_pkg::byte_t      i2c_rx_data,
	input  logic                i2c_rx_valid,
	output logic                imu_good,
	output logic                valid_strobe,
	output imu_pkg::axis_t      accel_x,
	output imu_pkg::axis_t      accel_y,
	output imu_pkg::axis_t      accel_z,
	output imu_pkg::axis_t      gyro_x,
	output imu_pkg::axis_t      gyro_y,
	output imu_pkg::axis_t      gyro_z,
	output imu_pkg::axis_t      euler_x,
	output imu_pkg::axis_t      euler_y,
	output imu_pkg::axis_t      euler_z,
	output imu_pkg::byte_t      temperature,
	output imu_pkg::byte_t      calib_status
);
	logic              timer_load;
	imu_pkg::wait_ms_t timer_ms;
	logic              timer_expired;

	imu_rx_if rx_bus ();

	assign rx_bus.rx_data  = i2c_rx_data; // Engine read path
	assign rx_bus.rx_valid = i2c_rx_valid;

	imu_ms_timer #(
		.CYCLES_PER_MS (CYCLES_PER_MS)
	) u_timer (
		.sys_clk (sys_clk),
		.rstn    (rstn),
		.load    (timer_load),
		.wait_ms (timer_ms),
		.expired (timer_expired)
	);

	imu_sequencer #(
		.BOOT_MS (BOOT_MS)
	) u_sequencer (
		.sys_clk        (sys_clk),
		.rstn           (rstn),
		.timer_load     (timer_load),
		.timer_ms       (timer_ms),
		.timer_expired  (timer_expired),
		.i2c_go         (i2c_go),
		.i2c_read       (i2c_read),
		.i2c_reg_addr   (i2c_reg_addr),
		.i2c_wdata      (i2c_wdata),
		.i2c_read_count (i2c_read_count),
		.i2c_busy       (i2c_busy),
		.rx             (rx_bus.seq),
		.imu_good       (imu_good)
	);

	imu_burst_capture u_capture (
		.sys_clk      (sys_clk),
		.rstn         (rstn),
		.rx           (rx_bus.cap),
		.valid_strobe (valid_strobe),
		.accel_x      (accel_x),
		.accel_y      (accel_y),
		.accel_z      (accel_z),
		.gyro_x       (gyro_x),
		.gyro_y       (gyro_y),
		.gyro_z       (gyro_z),
		.euler_x      (euler_x),
		.euler_y      (euler_y),
		.euler_z      (euler_z),
		.temperature  (temperature),
		.calib_status (calib_status)
	);

endmodule

// ==== imu_burst_capture.sv ====
// Measurement burst capture
// Stages the kept bytes by burst position and latches them as output fields

`timescale 1ns/1ps
`include "imu_cfg.svh"

module imu_burst_capture (
	input  logic            sys_clk,
	input  logic            rstn,
	imu_rx_if.cap           rx,
	output logic            valid_strobe, // Fields updated this cycle
	output imu_pkg::axis_t  accel_x,
	output imu_pkg::axis_t  accel_y,
	output imu_pkg::axis_t  accel_z,
	output imu_pkg::axis_t  gyro_x,
	output imu_pkg::axis_t  gyro_y,
	output imu_pkg::axis_t  gyro_z,
	output imu_pkg::axis_t  euler_x,
	output imu_pkg::axis_t  euler_y,
	output imu_pkg::axis_t  euler_z,
	output imu_pkg::byte_t  temperature,
	output imu_pkg::byte_t  calib_status
);
	imu_pkg::byte_t acc_stage [`IMU_GROUP_BYTES]; // LSB, MSB per axis, x first
	imu_pkg::byte_t gyr_stage [`IMU_GROUP_BYTES];
	imu_pkg::byte_t eul_stage [`IMU_GROUP_BYTES];
	imu_pkg::byte_t temp_stage;
	imu_pkg::byte_t calib_stage;

	function automatic imu_pkg::axis_t axis_of(input imu_pkg::byte_t lsb,
		input imu_pkg::byte_t msb);
		return imu_pkg::axis_t'({msb, lsb});
	endfunction

	// Burst position, wraps after the last byte
	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn)
			rx.rx_idx <= '0;
		else if (rx.rx_restart)
			rx.rx_idx <= '0;
		else if (rx.rx_valid) begin
			if (rx.rx_idx == imu_pkg::burst_idx_t'(`IMU_BURST_LEN - 1))
				rx.rx_idx <= '0;
			else
				rx.rx_idx <= rx.rx_idx + 1'b1;
		end
	end

	// Magnetometer, quaternion, linear and gravity bytes fall through
	always_ff @(posedge sys_clk) begin
		if (rx.rx_valid) begin
			for (int i = 0; i < `IMU_GROUP_BYTES; i++) begin
				if (rx.rx_idx == imu_pkg::burst_idx_t'(`IMU_ACC_OFS + i))
					acc_stage[i] <= rx.rx_data;
				if (rx.rx_idx == imu_pkg::burst_idx_t'(`IMU_GYR_OFS + i))
					gyr_stage[i] <= rx.rx_data;
				if (rx.rx_idx == imu_pkg::burst_idx_t'(`IMU_EUL_OFS + i))
					eul_stage[i] <= rx.rx_data;
			end
			if (rx.rx_idx == imu_pkg::burst_idx_t'(`IMU_TEMP_OFS))
				temp_stage <= rx.rx_data;
			if (rx.rx_idx == imu_pkg::burst_idx_t'(`IMU_CALIB_OFS))
				calib_stage <= rx.rx_data;
		end
	end

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			valid_strobe <= 1'b0;
			accel_x      <= '0;
			accel_y      <= '0;
			accel_z      <= '0;
			gyro_x       <= '0;
			gyro_y       <= '0;
			gyro_z       <= '0;
			euler_x      <= '0;
			euler_y      <= '0;
			euler_z      <= '0;
			temperature  <= '0;
			calib_status <= '0;
		end else begin
			valid_strobe <= rx.latch; // Same edge as the field update
			if (rx.latch) begin
				accel_x      <= axis_of(acc_stage[0], acc_stage[1]);
				accel_y      <= axis_of(acc_stage[2], acc_stage[3]);
				accel_z      <= axis_of(acc_stage[4], acc_stage[5]);
				gyro_x       <= axis_of(gyr_stage[0], gyr_stage[1]);
				gyro_y       <= axis_of(gyr_stage[2], gyr_stage[3]);
				gyro_z       <= axis_of(gyr_stage[4], gyr_stage[5]);
				euler_x      <= axis_of(eul_stage[0], eul_stage[1]); // Heading
				euler_y      <= axis_of(eul_stage[2], eul_stage[3]); // Roll
				euler_z      <= axis_of(eul_stage[4], eul_stage[5]); // Pitch
				temperature  <= temp_stage;
				calib_status <= calib_stage;
			end
		end
	end

endmodule

// ==== imu_cfg.svh ====
// BNO055 register map, configuration values, burst layout and wait times
// Shared by the sequencer, the burst capture block and the testbench
`ifndef IMU_CFG_SVH
`define IMU_CFG_SVH

// Page 0 register addresses
`define IMU_CHIP_ID_ADDR      8'h00 // Reads back 0xA0 on a live part
`define IMU_DATA_START_ADDR   8'h08 // ACC_DATA_X_LSB, head of the measurement block
`define IMU_UNIT_SEL_ADDR     8'h3B // Output units and orientation format
`define IMU_OPR_MODE_ADDR     8'h3D // Operation mode, CONFIG after boot
`define IMU_PWR_MODE_ADDR     8'h3E // Power mode
`define IMU_SYS_TRIGGER_ADDR  8'h3F // Clock source select lives in bit 7

// Values written during configuration
`define IMU_EXT_CRYSTAL       8'h80 // Switch to the external 32 kHz crystal
`define IMU_UNITS             8'h80 // Android orientation, Celsius, degrees, dps, m/s^2
`define IMU_PWR_NORMAL        8'h00 // Normal power mode
`define IMU_OPR_NDOF          8'h0C // Nine degrees of freedom fusion

// Measurement burst, 0x08 up to CALIB_STAT at 0x35
`define IMU_BURST_LEN         46

// Offsets of the LSB inside the burst, MSB follows at +1
`define IMU_AXIS_STRIDE       2                       // Bytes per axis
`define IMU_GROUP_BYTES       (3 * `IMU_AXIS_STRIDE)  // x, y, z in that order
`define IMU_ACC_OFS           0                       // Accelerometer
`define IMU_GYR_OFS           12                      // Gyroscope, after the magnetometer
`define IMU_EUL_OFS           18                      // Euler heading, roll, pitch
`define IMU_TEMP_OFS          44                      // Temperature byte
`define IMU_CALIB_OFS         45                      // Calibration status byte

// Delays in milliseconds
`define IMU_MODE_WAIT_MS      12'd20 // Mode switch takes up to 19 ms
`define IMU_POLL_MS           12'd10 // Poll period, 100 Hz

`endif

// ==== imu_ms_timer.sv ====
// Loadable millisecond down-counter with a level expiry flag

`timescale 1ns/1ps

module imu_ms_timer #(
	parameter int unsigned CYCLES_PER_MS = 50000
) (
	input  logic              sys_clk,
	input  logic              rstn,
	input  logic              load,    // Restart with a new delay
	input  imu_pkg::wait_ms_t wait_ms, // Delay, sampled with load
	output logic              expired  // High while the count is zero
);
	// Wide enough for the longest delay the type can express
	localparam int unsigned MAX_CYCLES = ((2 ** $bits(imu_pkg::wait_ms_t)) - 1) * CYCLES_PER_MS;
	localparam int unsigned CNT_W = $clog2(MAX_CYCLES + 1);

	logic [CNT_W-1:0] count; // Cycles left

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			count <= '0; // Starts out expired
		end else if (load) begin
			count <= CNT_W'(wait_ms) * CNT_W'(CYCLES_PER_MS);
		end else if (count != '0) begin
			count <= count - 1'b1; // Stops at zero
		end
	end

	assign expired = (count == '0);

endmodule

// ==== imu_pkg.sv ====
// Vector types and the sequencer state encoding for the BNO055 controller

package imu_pkg;

	typedef logic [7:0]        byte_t;      // One I2C data byte
	typedef logic signed [15:0] axis_t;     // One sensor axis, MSB:LSB
	typedef logic [5:0]        burst_idx_t; // Byte position in the burst, also read length
	typedef logic [11:0]       wait_ms_t;   // Delay in milliseconds

	typedef enum logic [3:0] {
		reset,           // Load boot timer
		boot_wait,       // Sensor power-on boot
		read_chip_id,    // Single byte read of CHIP_ID
		set_ext_crystal, // SYS_TRIGGER write
		set_units,       // UNIT_SEL write
		set_power_mode,  // PWR_MODE write
		set_run_mode,    // OPR_MODE write to NDOF
		wait_mode,       // Mode switch settle time
		poll_burst,      // Issue the measurement read
		wait_poll,       // Hold off until the poll period ends
		xfer_start,      // Go held until the engine reports busy
		xfer_wait,       // Transaction in flight
		xfer_stop        // Back to the stored major state
	} imu_state_t;

endpackage

// ==== imu_rx_if.sv ====
// Read-byte path and capture control between the sequencer and the burst capture

`timescale 1ns/1ps

interface imu_rx_if;
	imu_pkg::byte_t      rx_data;    // Byte from the I2C engine
	logic                rx_valid;   // One-cycle strobe per byte
	imu_pkg::burst_idx_t rx_idx;     // Burst position of the next byte
	logic                rx_restart; // Holds the index at zero
	logic                latch;      // Pulse at the end of a measurement read

	modport seq (output rx_restart, output latch);
	modport cap (input rx_data, input rx_valid, input rx_restart, input latch, output rx_idx);
endinterface

// ==== imu_sequencer.sv ====
// Boot, configuration and poll FSM for the BNO055
// Every register access runs through the shared start/wait/stop sub-states

`timescale 1ns/1ps
`include "imu_cfg.svh"

module imu_sequencer #(
	parameter int unsigned BOOT_MS = 650
) (
	input  logic                sys_clk,
	input  logic                rstn,
	output logic                timer_load,     // Restart the delay timer
	output imu_pkg::wait_ms_t   timer_ms,       // Delay for timer_load
	input  logic                timer_expired,
	output logic                i2c_go,         // Level, dropped once busy is seen
	output logic                i2c_read,       // 1 read, 0 write
	output imu_pkg::byte_t      i2c_reg_addr,
	output imu_pkg::byte_t      i2c_wdata,
	output imu_pkg::burst_idx_t i2c_read_count,
	input  logic                i2c_busy,
	imu_rx_if.seq               rx,
	output logic                imu_good        // First poll has completed
);
	imu_pkg::imu_state_t state;     // Current FSM state
	imu_pkg::imu_state_t ret_state; // Where xfer_stop goes next

	logic                cmd_issue; // State starts a transaction
	logic                cmd_read;
	imu_pkg::byte_t      cmd_addr;
	imu_pkg::byte_t      cmd_wdata;
	imu_pkg::burst_idx_t cmd_count;
	imu_pkg::imu_state_t cmd_ret;   // Return state for this transaction

	// Transaction issued by each major state
	always_comb begin
		cmd_issue = 1'b1;
		cmd_read  = 1'b0;
		cmd_addr  = '0;
		cmd_wdata = '0;
		cmd_count = imu_pkg::burst_idx_t'(1); // Writes are always one byte
		cmd_ret   = imu_pkg::reset;
		case (state)
			imu_pkg::read_chip_id: begin
				cmd_read = 1'b1;
				cmd_addr = `IMU_CHIP_ID_ADDR;
				cmd_ret  = imu_pkg::set_ext_crystal;
			end
			imu_pkg::set_ext_crystal: begin
				cmd_addr  = `IMU_SYS_TRIGGER_ADDR;
				cmd_wdata = `IMU_EXT_CRYSTAL;
				cmd_ret   = imu_pkg::set_units;
			end
			imu_pkg::set_units: begin
				cmd_addr  = `IMU_UNIT_SEL_ADDR;
				cmd_wdata = `IMU_UNITS;
				cmd_ret   = imu_pkg::set_power_mode;
			end
			imu_pkg::set_power_mode: begin
				cmd_addr  = `IMU_PWR_MODE_ADDR;
				cmd_wdata = `IMU_PWR_NORMAL;
				cmd_ret   = imu_pkg::set_run_mode;
			end
			imu_pkg::set_run_mode: begin
				cmd_addr  = `IMU_OPR_MODE_ADDR;
				cmd_wdata = `IMU_OPR_NDOF;
				cmd_ret   = imu_pkg::wait_mode; // Mode change needs settle time
			end
			imu_pkg::poll_burst: begin
				cmd_read  = 1'b1;
				cmd_addr  = `IMU_DATA_START_ADDR;
				cmd_count = imu_pkg::burst_idx_t'(`IMU_BURST_LEN);
				cmd_ret   = imu_pkg::wait_poll;
			end
			default: cmd_issue = 1'b0;
		endcase
	end

	// Timer loads, each lands on the edge that enters the waiting state
	always_comb begin
		timer_load = 1'b0;
		timer_ms   = imu_pkg::wait_ms_t'(BOOT_MS);
		case (state)
			imu_pkg::reset: timer_load = 1'b1; // Boot time
			imu_pkg::poll_burst: begin
				timer_load = 1'b1; // Poll period runs from the burst start
				timer_ms   = `IMU_POLL_MS;
			end
			imu_pkg::xfer_stop: begin
				timer_load = (ret_state == imu_pkg::wait_mode);
				timer_ms   = `IMU_MODE_WAIT_MS;
			end
			default: timer_load = 1'b0;
		endcase
	end

	// Byte index held at zero whenever no read can be in flight
	assign rx.rx_restart = state inside {imu_pkg::reset, imu_pkg::boot_wait,
		imu_pkg::wait_mode, imu_pkg::wait_poll};
	assign rx.latch = (state == imu_pkg::xfer_stop) && (ret_state == imu_pkg::wait_poll);

	always_ff @(posedge sys_clk or negedge rstn) begin
		if (!rstn) begin
			state          <= imu_pkg::reset;
			ret_state      <= imu_pkg::reset;
			i2c_go         <= 1'b0;
			i2c_read       <= 1'b1;
			i2c_reg_addr   <= '0;
			i2c_wdata      <= '0;
			i2c_read_count <= '0;
			imu_good       <= 1'b0;
		end else begin
			case (state)
				imu_pkg::reset: state <= imu_pkg::boot_wait;
				imu_pkg::boot_wait: begin
					if (timer_expired && !i2c_busy)
						state <= imu_pkg::read_chip_id; // Sensor booted, engine idle
				end
				imu_pkg::wait_mode, imu_pkg::wait_poll: begin
					if (timer_expired)
						state <= imu_pkg::poll_burst;
				end
				imu_pkg::xfer_start: begin
					if (i2c_busy) begin
						i2c_go <= 1'b0; // Engine took the command
						state  <= imu_pkg::xfer_wait;
					end
				end
				imu_pkg::xfer_wait: begin
					if (!i2c_busy)
						state <= imu_pkg::xfer_stop; // Transaction ended
				end
				imu_pkg::xfer_stop: begin
					state <= ret_state;
					if (ret_state == imu_pkg::wait_poll)
						imu_good <= 1'b1; // Stays set until reset
				end
				default: begin
					if (cmd_issue) begin
						i2c_go         <= 1'b1; // Raised with the command fields
						i2c_read       <= cmd_read;
						i2c_reg_addr   <= cmd_addr;
						i2c_wdata      <= cmd_wdata;
						i2c_read_count <= cmd_count;
						ret_state      <= cmd_ret;
						state          <= imu_pkg::xfer_start;
					end else begin
						state <= imu_pkg::reset; // Unused encoding
					end
				end
			endcase
		end
	end

endmodule

// ==== tb_bno055_driver.sv ====
// Testbench top for the BNO055 controller with a behavioral I2C engine
// Transaction order, field unpacking, poll timing, status and reset checks

`timescale 1ns/1ps
`include "imu_cfg.svh"

module tb_bno055_driver;
	localparam int CYCLES_PER_MS = 20;
	localparam int BOOT_MS       = 30;
	localparam int POLL_CYCLES   = `IMU_POLL_MS * CYCLES_PER_MS; // 200 cycles
	localparam int TXN_TIMEOUT   = 2000; // Cycles allowed per transaction wait

	typedef struct packed {
		logic [8:0][15:0] axis;  // Accel, gyro, Euler, x y z each
		logic [7:0]       temp;
		logic [7:0]       calib;
	} fields_t;

	typedef struct packed {
		logic       read;
		logic [7:0] addr;
		logic [7:0] wdata;
		logic [5:0] count;
	} txn_t;

	logic sys_clk;
	logic rstn;
	logic i2c_go, i2c_read, i2c_busy, i2c_rx_valid, imu_good, valid_strobe;
	imu_pkg::byte_t      i2c_reg_addr, i2c_wdata, i2c_rx_data, temperature, calib_status;
	imu_pkg::burst_idx_t i2c_read_count;
	imu_pkg::axis_t      accel_x, accel_y, accel_z, gyro_x, gyro_y, gyro_z;
	imu_pkg::axis_t      euler_x, euler_y, euler_z;

	txn_t        txn_q [$];           // Transactions since the last reset
	fields_t     exp_q [$];           // Expected fields per ended burst
	int unsigned end_q [$];           // Cycle of each burst end
	logic [`IMU_BURST_LEN-1:0][7:0] burst_bytes;
	int          byte_cnt     = 0;
	int unsigned cyc          = 0;    // Rising edges so far
	int unsigned rel_cyc      = 0;    // Cycle of the reset release
	int unsigned first_go     = 0;
	int unsigned last_go      = 0;    // Go of the latest burst
	int unsigned last_end     = 0;    // End of the latest burst
	logic        have_burst   = 1'b0;
	logic        last_long    = 1'b0; // Latest burst overran the poll period
	logic        go_prev      = 1'b0;
	logic        busy_prev    = 1'b0;
	int          bursts_ended = 0;
	int          strobe_cnt   = 0;
	int          long_bursts  = 0;

	initial sys_clk = 1'b0;
	always #50 sys_clk = ~sys_clk; // 100 ns period

	bno055_driver #(
		.CYCLES_PER_MS (CYCLES_PER_MS),
		.BOOT_MS       (BOOT_MS)
	) u_dut (
		.sys_clk (sys_clk), .rstn (rstn),
		.i2c_go (i2c_go), .i2c_read (i2c_read), .i2c_reg_addr (i2c_reg_addr),
		.i2c_wdata (i2c_wdata), .i2c_read_count (i2c_read_count), .i2c_busy (i2c_busy),
		.i2c_rx_data (i2c_rx_data), .i2c_rx_valid (i2c_rx_valid),
		.imu_good (imu_good), .valid_strobe (valid_strobe),
		.accel_x (accel_x), .accel_y (accel_y), .accel_z (accel_z),
		.gyro_x (gyro_x), .gyro_y (gyro_y), .gyro_z (gyro_z),
		.euler_x (euler_x), .euler_y (euler_y), .euler_z (euler_z),
		.temperature (temperature), .calib_status (calib_status)
	);

	tb_i2c_model u_model (
		.sys_clk (sys_clk), .rstn (rstn), .go (i2c_go), .read (i2c_read),
		.reg_addr (i2c_reg_addr), .wdata (i2c_wdata), .read_count (i2c_read_count),
		.busy (i2c_busy), .rx_data (i2c_rx_data), .rx_valid (i2c_rx_valid)
	);

	task automatic report_mismatch(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopped on an error");
	endtask

	// Expected outputs from the register map with the LSB first on the bus
	function automatic fields_t expected_fields(input logic [`IMU_BURST_LEN-1:0][7:0] b);
		fields_t f;
		int      base;
		int      g;
		int      a;
		for (g = 0; g < 3; g++) begin
			base = (g == 0) ? `IMU_ACC_OFS : (g == 1) ? `IMU_GYR_OFS : `IMU_EUL_OFS;
			for (a = 0; a < 3; a++)
				f.axis[3 * g + a] = {b[base + 2 * a + 1], b[base + 2 * a]};
		end
		f.temp  = b[`IMU_TEMP_OFS];
		f.calib = b[`IMU_CALIB_OFS];
		return f;
	endfunction

	function automatic string axis_name(input int i);
		return $sformatf("%s_%s", (i < 3) ? "accel" : (i < 6) ? "gyro" : "euler",
			(i % 3 == 0) ? "x" : (i % 3 == 1) ? "y" : "z");
	endfunction

	task automatic log_go();
		txn_t t;
		t = '{read: i2c_read, addr: i2c_reg_addr, wdata: i2c_wdata, count: i2c_read_count};
		if (txn_q.size() == 0)
			first_go = cyc;
		if (txn_q.size() >= 5) // Past configuration only bursts
			assert (t.read && t.addr == `IMU_DATA_START_ADDR && t.count == `IMU_BURST_LEN)
			else report_mismatch($sformatf("transaction %0d is not a burst read", txn_q.size()));
		if (t.read && t.addr == `IMU_DATA_START_ADDR) begin
			if (have_burst) begin
				assert (cyc - last_go >= POLL_CYCLES)
				else report_mismatch($sformatf("bursts only %0d cycles apart", cyc - last_go));
				if (last_long)
					assert (cyc - last_end <= 4)
					else report_mismatch($sformatf("go %0d cycles after a long burst", cyc - last_end));
			end
			have_burst = 1'b1;
			last_go    = cyc;
		end
		txn_q.push_back(t);
		byte_cnt = 0;
	endtask

	task automatic end_xfer();
		txn_t t;
		t = txn_q[$];
		if (t.read && t.addr == `IMU_DATA_START_ADDR) begin
			assert (byte_cnt == `IMU_BURST_LEN)
			else report_mismatch($sformatf("burst delivered %0d bytes", byte_cnt));
			exp_q.push_back(expected_fields(burst_bytes));
			end_q.push_back(cyc);
			last_long = (cyc - last_go) > POLL_CYCLES;
			last_end  = cyc;
			if (last_long)
				long_bursts++;
			bursts_ended <= bursts_ended + 1;
		end
	endtask

	// Bus monitor on pre-edge values
	always @(posedge sys_clk) begin
		cyc <= cyc + 1;
		if (!rstn) begin
			txn_q.delete();
			exp_q.delete();
			end_q.delete();
			byte_cnt     = 0;
			have_burst   = 1'b0;
			last_long    = 1'b0;
			go_prev      = 1'b0;
			busy_prev    = 1'b0;
			bursts_ended <= 0;
		end else begin
			if (i2c_go && !go_prev)
				log_go();
			if (i2c_rx_valid) begin
				if (byte_cnt < `IMU_BURST_LEN)
					burst_bytes[byte_cnt] = i2c_rx_data;
				byte_cnt++;
			end
			if (busy_prev && !i2c_busy)
				end_xfer(); // First cycle with busy low
			go_prev   = i2c_go;
			busy_prev = i2c_busy;
		end
	end

	task automatic compare_strobe();
		fields_t     exp;
		fields_t     got;
		int unsigned ended;
		int          i;
		assert (exp_q.size() != 0) else report_mismatch("valid_strobe without a completed burst");
		exp   = exp_q.pop_front();
		ended = end_q.pop_front();
		got.axis  = {euler_z, euler_y, euler_x, gyro_z, gyro_y, gyro_x, accel_z, accel_y, accel_x};
		got.temp  = temperature;
		got.calib = calib_status;
		assert (cyc - ended == 2)
		else report_mismatch($sformatf("strobe %0d cycles after burst end", cyc - ended));
		for (i = 0; i < 9; i++)
			assert (got.axis[i] == exp.axis[i])
			else report_mismatch($sformatf("%s is %04h, expected %04h", axis_name(i),
				got.axis[i], exp.axis[i]));
		assert (got.temp == exp.temp)
		else report_mismatch($sformatf("temperature is %02h, expected %02h", got.temp, exp.temp));
		assert (got.calib == exp.calib)
		else report_mismatch($sformatf("calib_status is %02h, expected %02h", got.calib, exp.calib));
	endtask

	// Strobe and status checker
	always @(posedge sys_clk) begin
		if (!rstn) begin
			strobe_cnt <= 0;
		end else begin
			if (bursts_ended == 0)
				assert (!imu_good) else report_mismatch("imu_good high before the first burst");
			if (strobe_cnt > 0)
				assert (imu_good) else report_mismatch("imu_good low after a strobe");
			if (valid_strobe) begin
				compare_strobe();
				strobe_cnt <= strobe_cnt + 1;
			end
		end
	end

	task automatic check_idle();
		assert (!i2c_go && !valid_strobe && !imu_good)
		else report_mismatch("go, valid_strobe or imu_good high in reset");
		assert (accel_x == 0 && accel_y == 0 && accel_z == 0 && gyro_x == 0 && gyro_y == 0
			&& gyro_z == 0 && euler_x == 0 && euler_y == 0 && euler_z == 0
			&& temperature == 0 && calib_status == 0)
		else report_mismatch("measurement fields not zero in reset");
	endtask

	task automatic hold_reset();
		repeat (16) begin
			@(posedge sys_clk);
			#1 check_idle();
		end
		rstn = 1'b1;
		rel_cyc = cyc;
	endtask

	task automatic wait_txns(input int n);
		int waited;
		waited = 0;
		while (txn_q.size() < n) begin
			@(posedge sys_clk);
			waited++;
			if (waited > TXN_TIMEOUT)
				report_error($sformatf("transaction %0d did not start in time", n));
		end
	endtask

	task automatic check_txn(input int idx, input logic rd, input logic [7:0] addr,
		input logic [7:0] data, input int cnt);
		txn_t t;
		wait_txns(idx + 1);
		t = txn_q[idx];
		assert (t.read == rd && t.addr == addr && (rd || t.wdata == data)
			&& (!rd || t.count == cnt))
		else report_mismatch($sformatf("transaction %0d: read %0b addr %02h data %02h count %0d",
			idx, t.read, t.addr, t.wdata, t.count));
	endtask

	task automatic check_config();
		check_txn(0, 1'b1, `IMU_CHIP_ID_ADDR, 8'h00, 1);
		assert (first_go - rel_cyc >= BOOT_MS * CYCLES_PER_MS)
		else report_mismatch($sformatf("first go %0d cycles after reset", first_go - rel_cyc));
		check_txn(1, 1'b0, `IMU_SYS_TRIGGER_ADDR, `IMU_EXT_CRYSTAL, 1);
		check_txn(2, 1'b0, `IMU_UNIT_SEL_ADDR, `IMU_UNITS, 1);
		check_txn(3, 1'b0, `IMU_PWR_MODE_ADDR, `IMU_PWR_NORMAL, 1);
		check_txn(4, 1'b0, `IMU_OPR_MODE_ADDR, `IMU_OPR_NDOF, 1);
		check_txn(5, 1'b1, `IMU_DATA_START_ADDR, 8'h00, `IMU_BURST_LEN);
	endtask

	task automatic wait_strobes(input int n);
		int waited;
		waited = 0;
		while (strobe_cnt < n) begin
			@(posedge sys_clk);
			waited++;
			if (waited > n * 1000)
				report_error($sformatf("only %0d of %0d strobes arrived", strobe_cnt, n));
		end
	endtask

	// Returns once one more measurement burst has ended
	task automatic wait_burst_end();
		int start;
		int waited;
		start  = bursts_ended;
		waited = 0;
		while (bursts_ended == start) begin
			@(posedge sys_clk);
			waited++;
			if (waited > TXN_TIMEOUT)
				report_error("no further burst ended in time");
		end
	endtask

	// Lands on an edge with a measurement burst in flight
	task automatic wait_burst_busy();
		int waited;
		waited = 0;
		while (!(i2c_busy && txn_q.size() > 5)) begin
			@(posedge sys_clk);
			waited++;
			if (waited > TXN_TIMEOUT)
				report_error("no burst read started before the reset");
		end
	endtask

	initial begin
		rstn = 1'b0;
		hold_reset();
		check_config();
		wait_strobes(6);
		wait_burst_busy();
		#1 rstn = 1'b0; // Reset in the middle of a burst
		hold_reset();
		check_config(); // Boot and configuration run again
		wait_strobes(3);
		wait_burst_end();
		repeat (3) @(posedge sys_clk); // Strobe is due two cycles after the end
		assert (exp_q.size() == 0) else report_mismatch("a completed burst had no strobe");
		if (long_bursts == 0) begin
			report_error("no burst was stretched past the poll period");
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

// ==== tb_i2c_model.sv ====
// Behavioral I2C engine and BNO055 sensor model for the testbench
// Answers go with busy, returns LFSR read bytes and logs every transaction

`timescale 1ns/1ps

module tb_i2c_model (
	input  logic                sys_clk,
	input  logic                rstn,
	input  logic                go,
	input  logic                read,
	input  imu_pkg::byte_t      reg_addr,
	input  imu_pkg::byte_t      wdata,
	input  imu_pkg::burst_idx_t read_count,
	output logic                busy,
	output imu_pkg::byte_t      rx_data,
	output logic                rx_valid
);
	logic [31:0] lfsr_state = 32'd75380; // Fixed seed

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic int rand_bits(input int n);
		int v;
		int i;
		v = 0;
		for (i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	task automatic run_xfer();
		logic           rd;
		imu_pkg::byte_t addr;
		imu_pkg::byte_t data;
		int             cnt;
		int             extra;
		int             i;
		string          line;
		rd   = read; // Command fields are stable while go is high
		addr = reg_addr;
		data = wdata;
		cnt  = int'(read_count);
		line = "";
		repeat (1 + rand_bits(2)) @(posedge sys_clk); // Engine start latency
		#1 busy = 1'b1;
		if (rd) begin
			for (i = 0; i < cnt; i++) begin
				repeat (1 + rand_bits(2)) @(posedge sys_clk); // Byte spacing
				#1 rx_data = imu_pkg::byte_t'(rand_bits(8));
				rx_valid = 1'b1;
				line = {line, $sformatf(" %02h", rx_data)};
				@(posedge sys_clk);
				#1 rx_valid = 1'b0;
			end
			$display("%0t model read 0x%02h x%0d:%s", $time, addr, cnt, line);
		end else begin
			$display("%0t model write 0x%02h <- 0x%02h", $time, addr, data);
		end
		// Half the transactions hold busy long enough to overrun the poll period
		extra = (rand_bits(1) == 1) ? 100 + rand_bits(7) : rand_bits(3);
		repeat (1 + extra) @(posedge sys_clk);
		#1 busy = 1'b0;
	endtask

	initial begin
		busy     = 1'b0;
		rx_valid = 1'b0;
		rx_data  = '0;
		forever begin
			@(posedge sys_clk);
			if (rstn && go && !busy) begin
				fork
					run_xfer();
					@(negedge rstn); // Reset aborts the transaction
				join_any
				disable fork;
				busy     = 1'b0;
				rx_valid = 1'b0;
			end
		end
	end

endmodule
